/* source/core_if_pkg.sv */
// ------------------
// Core-side data memory interface types
// Load/store request and reply records
// and the AMO request format of the core
// ------------------
`default_nettype none

package core_if_pkg;

    // AMO operation as issued by the core
    typedef enum logic [3:0] {
        AMO_NONE,
        AMO_LR,
        AMO_SC,
        AMO_SWAP,
        AMO_ADD,
        AMO_AND,
        AMO_OR,
        AMO_XOR,
        AMO_MAX,
        AMO_MAXU,
        AMO_MIN,
        AMO_MINU
    } amo_op_e;

    // Load or store request, held by the core until gnt
    typedef struct packed {
        logic        req;
        logic [31:0] addr;
        logic [63:0] wdata;
        logic [7:0]  be;
        logic [1:0]  size;
        logic [3:0]  id;
    } core_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [63:0] rdata;
        logic [3:0]  rid;
    } core_rsp_t;

    // Address travels in operand_a, operand in operand_b
    typedef struct packed {
        logic        req;
        amo_op_e     op;
        logic [1:0]  size;
        logic [63:0] operand_a;
        logic [63:0] operand_b;
    } amo_req_t;

    typedef struct packed {
        logic        ack;
        logic [63:0] result;
    } amo_rsp_t;

endpackage

`default_nettype wire

/* source/dcache_if_pkg.sv */
// ------------------
// L1 data cache request channel types
// Request/response records, opcodes,
// id widths and reserved transaction ids
// ------------------
`default_nettype none

package dcache_if_pkg;

    localparam int unsigned OffsetWidth = 12;
    localparam int unsigned TagWidth    = 20;
    localparam int unsigned SidWidth    = 1;
    localparam int unsigned TidWidth    = 4;

    typedef logic [SidWidth-1:0] dcache_sid_t;
    typedef logic [TidWidth-1:0] dcache_tid_t;

    // Reserved ids on the store/AMO port
    localparam dcache_tid_t TidAmo   = '1;
    localparam dcache_tid_t TidFlush = '0;

    typedef enum logic [3:0] {
        DCACHE_LOAD,
        DCACHE_STORE,
        DCACHE_AMO_LR,
        DCACHE_AMO_SC,
        DCACHE_AMO_SWAP,
        DCACHE_AMO_ADD,
        DCACHE_AMO_AND,
        DCACHE_AMO_OR,
        DCACHE_AMO_XOR,
        DCACHE_AMO_MAX,
        DCACHE_AMO_MAXU,
        DCACHE_AMO_MIN,
        DCACHE_AMO_MINU,
        DCACHE_FLUSH_ALL
    } dcache_op_e;

    typedef struct packed {
        logic [OffsetWidth-1:0] addr_offset;
        logic [TagWidth-1:0]    addr_tag;
        logic [63:0]            wdata;
        logic [7:0]             be;
        logic [1:0]             size;
        dcache_op_e             op;
        dcache_sid_t            sid;
        dcache_tid_t            tid;
        logic                   need_rsp;
        logic                   uncacheable;
    } dcache_req_t;

    typedef struct packed {
        logic [63:0] rdata;
        dcache_sid_t sid;
        dcache_tid_t tid;
    } dcache_rsp_t;

    // Anything outside [base, base + size) bypasses the cache
    function automatic logic is_uncacheable(input logic [31:0] addr,
                                            input logic [31:0] base,
                                            input logic [31:0] size);
        return !((addr >= base) && ((addr - base) < size));
    endfunction

endpackage

`default_nettype wire

/* source/load_port_adapter.sv */
// ------------------
// Load port adapter
// Core load requests to cache LOAD records,
// cache responses back to the core
// ------------------
`default_nettype none

module load_port_adapter #(
    parameter logic [31:0]               CacheableBase = 32'h8000_0000,
    parameter logic [31:0]               CacheableSize = 32'h4000_0000,
    parameter dcache_if_pkg::dcache_sid_t LoadSid      = 1'b0
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire core_if_pkg::core_req_t    core_req_i,
    output core_if_pkg::core_rsp_t         core_rsp_o,
    output logic                           req_valid_o,
    input  wire logic                      req_ready_i,
    output dcache_if_pkg::dcache_req_t     req_o,
    input  wire logic                      rsp_valid_i,
    input  wire dcache_if_pkg::dcache_rsp_t rsp_i
);
    import dcache_if_pkg::*;

    assign req_valid_o = core_req_i.req;

    assign req_o = '{
        addr_offset: core_req_i.addr[OffsetWidth-1:0],
        addr_tag:    core_req_i.addr[OffsetWidth +: TagWidth],
        wdata:       '0,
        be:          core_req_i.be,
        size:        core_req_i.size,
        op:          DCACHE_LOAD,
        sid:         LoadSid,
        tid:         core_req_i.id,
        need_rsp:    1'b1,
        uncacheable: is_uncacheable(core_req_i.addr, CacheableBase, CacheableSize)
    };

    // Ready from the arbiter already includes the port grant
    assign core_rsp_o.gnt    = req_ready_i;
    assign core_rsp_o.rvalid = rsp_valid_i;
    assign core_rsp_o.rdata  = rsp_i.rdata;
    assign core_rsp_o.rid    = rsp_i.tid;

    // TidAmo is owned by the store/AMO port
    load_id_not_amo_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_req_i.req |-> core_req_i.id != TidAmo)
        else $error("load id collides with the reserved AMO tid");

endmodule

`default_nettype wire

/* source/store_amo_adapter.sv */
// ------------------
// Store/AMO port adapter
// Stores, word/doubleword AMOs and flush-all
// onto one cache request, with AMO tracking
// and a flush FSM on the response side
// ------------------
`default_nettype none

module store_amo_adapter #(
    parameter logic [31:0]               CacheableBase = 32'h8000_0000,
    parameter logic [31:0]               CacheableSize = 32'h4000_0000,
    parameter dcache_if_pkg::dcache_sid_t StoreSid     = 1'b1
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire core_if_pkg::core_req_t    core_req_i,
    output core_if_pkg::core_rsp_t         core_rsp_o,
    input  wire core_if_pkg::amo_req_t     amo_req_i,
    output core_if_pkg::amo_rsp_t          amo_rsp_o,
    input  wire logic                      flush_i,
    output logic                           flush_ack_o,
    output logic                           req_valid_o,
    input  wire logic                      req_ready_i,
    output dcache_if_pkg::dcache_req_t     req_o,
    input  wire logic                      rsp_valid_i,
    input  wire dcache_if_pkg::dcache_rsp_t rsp_i
);
    import core_if_pkg::*;
    import dcache_if_pkg::*;

    typedef enum logic [0:0] {
        FLUSH_IDLE,
        FLUSH_PEND
    } flush_state_e;

    flush_state_e flush_state_q, flush_state_d;
    logic         amo_pending_q;
    logic         amo_fwd, store_fwd, flush_fwd;
    logic         amo_is_word, amo_hi;
    logic [31:0]  amo_addr;
    logic [31:0]  amo_rsp_word;
    logic         flush_rsp;
    dcache_op_e   amo_op;
    dcache_req_t  amo_req, store_req, flush_req;

    // AMO first unless one is already in flight, then store, then flush
    assign amo_fwd   = amo_req_i.req && !amo_pending_q;
    assign store_fwd = core_req_i.req && !amo_fwd;
    assign flush_fwd = flush_i && (flush_state_q == FLUSH_IDLE)
                       && !amo_fwd && !core_req_i.req;

    assign amo_addr    = amo_req_i.operand_a[31:0];
    assign amo_is_word = (amo_req_i.size == 2'b10);
    assign amo_hi      = amo_addr[2];

    always_comb begin
        case (amo_req_i.op)
            AMO_LR:   amo_op = DCACHE_AMO_LR;
            AMO_SC:   amo_op = DCACHE_AMO_SC;
            AMO_SWAP: amo_op = DCACHE_AMO_SWAP;
            AMO_ADD:  amo_op = DCACHE_AMO_ADD;
            AMO_AND:  amo_op = DCACHE_AMO_AND;
            AMO_OR:   amo_op = DCACHE_AMO_OR;
            AMO_XOR:  amo_op = DCACHE_AMO_XOR;
            AMO_MAX:  amo_op = DCACHE_AMO_MAX;
            AMO_MAXU: amo_op = DCACHE_AMO_MAXU;
            AMO_MIN:  amo_op = DCACHE_AMO_MIN;
            AMO_MINU: amo_op = DCACHE_AMO_MINU;
            default:  amo_op = DCACHE_LOAD;
        endcase
    end

    // Word operand is duplicated, be picks the half
    assign amo_req = '{
        addr_offset: amo_addr[OffsetWidth-1:0],
        addr_tag:    amo_addr[OffsetWidth +: TagWidth],
        wdata:       amo_is_word ? {2{amo_req_i.operand_b[31:0]}} : amo_req_i.operand_b,
        be:          amo_is_word ? (amo_hi ? 8'hf0 : 8'h0f) : 8'hff,
        size:        amo_req_i.size,
        op:          amo_op,
        sid:         StoreSid,
        tid:         TidAmo,
        need_rsp:    1'b1,
        uncacheable: is_uncacheable(amo_addr, CacheableBase, CacheableSize)
    };

    assign store_req = '{
        addr_offset: core_req_i.addr[OffsetWidth-1:0],
        addr_tag:    core_req_i.addr[OffsetWidth +: TagWidth],
        wdata:       core_req_i.wdata,
        be:          core_req_i.be,
        size:        core_req_i.size,
        op:          DCACHE_STORE,
        sid:         StoreSid,
        tid:         TidFlush,
        need_rsp:    1'b0,
        uncacheable: is_uncacheable(core_req_i.addr, CacheableBase, CacheableSize)
    };

    assign flush_req = '{
        op:      DCACHE_FLUSH_ALL,
        sid:     StoreSid,
        tid:     TidFlush,
        need_rsp: 1'b1,
        default: '0
    };

    assign req_valid_o = amo_fwd || store_fwd || flush_fwd;
    assign req_o       = amo_fwd ? amo_req : (store_fwd ? store_req : flush_req);

    // Flush waits for its own response before acking the core
    assign flush_rsp = rsp_valid_i && (flush_state_q == FLUSH_PEND) && (rsp_i.tid == TidFlush);

    always_comb begin
        flush_state_d = flush_state_q;
        case (flush_state_q)
            FLUSH_IDLE: if (flush_fwd && req_ready_i) flush_state_d = FLUSH_PEND;
            FLUSH_PEND: if (flush_rsp) flush_state_d = FLUSH_IDLE;
            default:    flush_state_d = FLUSH_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            flush_state_q <= FLUSH_IDLE;
            amo_pending_q <= 1'b0;
        end else begin
            flush_state_q <= flush_state_d;
            amo_pending_q <= (amo_fwd && req_ready_i) || (amo_pending_q && !amo_rsp_o.ack);
        end
    end

    assign flush_ack_o = flush_rsp;

    // AMO request stays held until ack, so its size and addr still apply here
    assign amo_rsp_word     = amo_hi ? rsp_i.rdata[63:32] : rsp_i.rdata[31:0];
    assign amo_rsp_o.ack    = rsp_valid_i && (rsp_i.tid == TidAmo);
    assign amo_rsp_o.result = amo_is_word ? {{32{amo_rsp_word[31]}}, amo_rsp_word}
                                          : rsp_i.rdata;

    assign core_rsp_o.gnt    = store_fwd && req_ready_i;
    assign core_rsp_o.rvalid = rsp_valid_i && !amo_rsp_o.ack && !flush_rsp;
    assign core_rsp_o.rdata  = rsp_i.rdata;
    assign core_rsp_o.rid    = rsp_i.tid;

    one_source_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({store_fwd, amo_fwd, flush_fwd}))
        else $error("more than one store/AMO/flush request forwarded");

    // Cache never answers an AMO that was not issued
    amo_ack_pending_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        amo_rsp_o.ack |-> amo_pending_q)
        else $error("AMO ack without a pending AMO");

endmodule

`default_nettype wire

/* source/dcache_req_arbiter.sv */
// ------------------
// Cache request arbiter
// Fixed priority merge of the load and
// store/AMO ports, responses routed by sid
// ------------------
`default_nettype none

module dcache_req_arbiter #(
    parameter dcache_if_pkg::dcache_sid_t LoadSid  = 1'b0,
    parameter dcache_if_pkg::dcache_sid_t StoreSid = 1'b1
) (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire logic                       ld_valid_i,
    input  wire dcache_if_pkg::dcache_req_t ld_req_i,
    output logic                            ld_ready_o,
    input  wire logic                       st_valid_i,
    input  wire dcache_if_pkg::dcache_req_t st_req_i,
    output logic                            st_ready_o,
    output logic                            req_valid_o,
    input  wire logic                       req_ready_i,
    output dcache_if_pkg::dcache_req_t      req_o,
    input  wire logic                       rsp_valid_i,
    input  wire dcache_if_pkg::dcache_rsp_t rsp_i,
    output logic                            ld_rsp_valid_o,
    output logic                            st_rsp_valid_o,
    output dcache_if_pkg::dcache_rsp_t      rsp_o
);

    // Store port always wins
    assign req_valid_o = st_valid_i || ld_valid_i;
    assign req_o       = st_valid_i ? st_req_i : ld_req_i;

    // Ready doubles as the grant, so it only goes to the winner
    assign st_ready_o = req_ready_i && st_valid_i;
    assign ld_ready_o = req_ready_i && ld_valid_i && !st_valid_i;

    // sid was stamped by the adapters on the way out
    assign ld_rsp_valid_o = rsp_valid_i && (rsp_i.sid == LoadSid);
    assign st_rsp_valid_o = rsp_valid_i && (rsp_i.sid == StoreSid);
    assign rsp_o          = rsp_i;

    one_grant_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ld_ready_o && st_ready_o))
        else $error("both ports granted in one cycle");

    rsp_sid_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_i |-> (rsp_i.sid == LoadSid) || (rsp_i.sid == StoreSid))
        else $error("response with an unknown sid");

endmodule

`default_nettype wire

/* source/dcache_if_subsystem.sv */
// ------------------
// Data memory interface subsystem
// Load and store/AMO adapters merged onto
// one L1 data cache request channel
// ------------------
`default_nettype none

module dcache_if_subsystem #(
    parameter logic [31:0]               CacheableBase = 32'h8000_0000,
    parameter logic [31:0]               CacheableSize = 32'h4000_0000,
    parameter dcache_if_pkg::dcache_sid_t LoadSid      = 1'b0,
    parameter dcache_if_pkg::dcache_sid_t StoreSid     = 1'b1
) (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire core_if_pkg::core_req_t     ld_req_i,
    output core_if_pkg::core_rsp_t          ld_rsp_o,
    input  wire core_if_pkg::core_req_t     st_req_i,
    output core_if_pkg::core_rsp_t          st_rsp_o,
    input  wire core_if_pkg::amo_req_t      amo_req_i,
    output core_if_pkg::amo_rsp_t           amo_rsp_o,
    input  wire logic                       flush_i,
    output logic                            flush_ack_o,
    output logic                            req_valid_o,
    input  wire logic                       req_ready_i,
    output dcache_if_pkg::dcache_req_t      req_o,
    input  wire logic                       rsp_valid_i,
    input  wire dcache_if_pkg::dcache_rsp_t rsp_i
);
    import dcache_if_pkg::*;

    logic        ld_valid, ld_ready, ld_rsp_valid;
    logic        st_valid, st_ready, st_rsp_valid;
    dcache_req_t ld_req, st_req;
    dcache_rsp_t arb_rsp;

    load_port_adapter #(
        .CacheableBase(CacheableBase),
        .CacheableSize(CacheableSize),
        .LoadSid      (LoadSid)
    ) u_load (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .core_req_i (ld_req_i),
        .core_rsp_o (ld_rsp_o),
        .req_valid_o(ld_valid),
        .req_ready_i(ld_ready),
        .req_o      (ld_req),
        .rsp_valid_i(ld_rsp_valid),
        .rsp_i      (arb_rsp)
    );

    store_amo_adapter #(
        .CacheableBase(CacheableBase),
        .CacheableSize(CacheableSize),
        .StoreSid     (StoreSid)
    ) u_store (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .core_req_i (st_req_i),
        .core_rsp_o (st_rsp_o),
        .amo_req_i  (amo_req_i),
        .amo_rsp_o  (amo_rsp_o),
        .flush_i    (flush_i),
        .flush_ack_o(flush_ack_o),
        .req_valid_o(st_valid),
        .req_ready_i(st_ready),
        .req_o      (st_req),
        .rsp_valid_i(st_rsp_valid),
        .rsp_i      (arb_rsp)
    );

    dcache_req_arbiter #(
        .LoadSid (LoadSid),
        .StoreSid(StoreSid)
    ) u_arb (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .ld_valid_i    (ld_valid),
        .ld_req_i      (ld_req),
        .ld_ready_o    (ld_ready),
        .st_valid_i    (st_valid),
        .st_req_i      (st_req),
        .st_ready_o    (st_ready),
        .req_valid_o   (req_valid_o),
        .req_ready_i   (req_ready_i),
        .req_o         (req_o),
        .rsp_valid_i   (rsp_valid_i),
        .rsp_i         (rsp_i),
        .ld_rsp_valid_o(ld_rsp_valid),
        .st_rsp_valid_o(st_rsp_valid),
        .rsp_o         (arb_rsp)
    );

endmodule

`default_nettype wire

/* dv/tb_cache_model.sv */
// --------------------
// Behavioral L1 data cache model
// 16 doublewords, random back-pressure,
// one response per need_rsp request, next cycle
// --------------------
`default_nettype none

module tb_cache_model (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire logic                       req_valid_i,
    output logic                            req_ready_o,
    input  wire dcache_if_pkg::dcache_req_t req_i,
    output logic                            rsp_valid_o,
    output dcache_if_pkg::dcache_rsp_t      rsp_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_if_pkg::*;

    logic [63:0] mem [16];
    logic [3:0]  idx;

    assign idx = req_i.addr_offset[6:3];

    function automatic logic [63:0] sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic logic [63:0] amo_calc(input dcache_op_e op, input logic [63:0] a,
                                             input logic [63:0] b);
        case (op)
            DCACHE_AMO_SWAP, DCACHE_AMO_SC: return b;
            DCACHE_AMO_ADD:  return a + b;
            DCACHE_AMO_AND:  return a & b;
            DCACHE_AMO_OR:   return a | b;
            DCACHE_AMO_XOR:  return a ^ b;
            DCACHE_AMO_MAX:  return ($signed(a) > $signed(b)) ? a : b;
            DCACHE_AMO_MAXU: return (a > b) ? a : b;
            DCACHE_AMO_MIN:  return ($signed(a) < $signed(b)) ? a : b;
            DCACHE_AMO_MINU: return (a < b) ? a : b;
            default:         return a;
        endcase
    endfunction

    // Memory contents after the request has been applied
    function automatic logic [63:0] next_value(input dcache_req_t r, input logic [63:0] old);
        logic        hi;
        logic [63:0] res;
        hi  = r.be[4];
        res = old;
        if (r.op == DCACHE_STORE) begin
            for (int b = 0; b < 8; b++) begin
                if (r.be[b]) res[8*b +: 8] = r.wdata[8*b +: 8];
            end
            return res;
        end
        if (r.op inside {DCACHE_LOAD, DCACHE_FLUSH_ALL, DCACHE_AMO_LR}) return old;
        // Word AMO works on the half picked by be
        if (r.size == 2'b10) begin
            res = amo_calc(r.op, sext32(hi ? old[63:32] : old[31:0]),
                           sext32(hi ? r.wdata[63:32] : r.wdata[31:0]));
            return hi ? {res[31:0], old[31:0]} : {old[63:32], res[31:0]};
        end
        return amo_calc(r.op, old, r.wdata);
    endfunction

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_ready_o <= 1'b0;
            rsp_valid_o <= 1'b0;
            rsp_o       <= '0;
            for (int i = 0; i < 16; i++) begin
                mem[i] <= 64'(i) * 64'h0101_0101_0101_0101;
            end
        end else begin
            // Ready about three cycles in four
            req_ready_o <= ($urandom % 4) != 0;
            rsp_valid_o <= req_valid_i && req_ready_o && req_i.need_rsp;
            if (req_valid_i && req_ready_o) begin
                mem[idx]    <= next_value(req_i, mem[idx]);
                rsp_o.rdata <= (req_i.op inside {DCACHE_FLUSH_ALL, DCACHE_AMO_SC}) ? '0
                                                                                  : mem[idx];
                rsp_o.sid   <= req_i.sid;
                rsp_o.tid   <= req_i.tid;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_dcache_if_subsystem.sv */
// --------------------
// Testbench for the data memory interface
// Row table of loads, stores, AMOs, flush and
// a store/load collision against a cache model
// --------------------
`default_nettype none

module tb_dcache_if_subsystem;
    timeunit 1ns;
    timeprecision 1ps;
    import core_if_pkg::*;
    import dcache_if_pkg::*;

    localparam logic [31:0] CacheableBase = 32'h8000_0000;
    localparam logic [31:0] CacheableSize = 32'h4000_0000;
    localparam dcache_sid_t LoadSid       = 1'b0;
    localparam dcache_sid_t StoreSid      = 1'b1;
    localparam int unsigned NumRows       = 11;
    localparam int unsigned MaxCycles     = NumRows * 30 + 20;

    typedef enum logic [2:0] {K_LOAD, K_STORE, K_AMO, K_FLUSH, K_PAIR} kind_e;

    // exp is rdata or AMO result, wd/be/op/unc are the expected cache request
    typedef struct packed {
        kind_e        kind;
        amo_op_e      aop;
        logic [31:0]  addr;
        logic [63:0]  data;
        logic [7:0]   be;
        logic [1:0]   size;
        logic [3:0]   id;
        logic [63:0]  exp;
        logic [63:0]  wd;
        dcache_op_e   op;
        logic         unc;
        logic [127:0] name;
    } row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    core_req_t   ld_req, st_req;
    core_rsp_t   ld_rsp, st_rsp;
    amo_req_t    amo_req;
    amo_rsp_t    amo_rsp;
    logic        flush, flush_ack;
    logic        req_valid, req_ready, rsp_valid;
    dcache_req_t cache_req, last_req;
    dcache_rsp_t cache_rsp;

    row_t        rows [NumRows];
    int unsigned cycles      = 0;
    int unsigned amo_accepts = 0;
    logic        ld_waiting  = 1'b0;
    string       cur_name    = "reset";

    always #4 clk = ~clk;

    dcache_if_subsystem #(
        .CacheableBase(CacheableBase),
        .CacheableSize(CacheableSize),
        .LoadSid      (LoadSid),
        .StoreSid     (StoreSid)
    ) u_dut (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .ld_req_i   (ld_req),
        .ld_rsp_o   (ld_rsp),
        .st_req_i   (st_req),
        .st_rsp_o   (st_rsp),
        .amo_req_i  (amo_req),
        .amo_rsp_o  (amo_rsp),
        .flush_i    (flush),
        .flush_ack_o(flush_ack),
        .req_valid_o(req_valid),
        .req_ready_i(req_ready),
        .req_o      (cache_req),
        .rsp_valid_i(rsp_valid),
        .rsp_i      (cache_rsp)
    );

    tb_cache_model u_cache (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .req_valid_i(req_valid),
        .req_ready_o(req_ready),
        .req_i      (cache_req),
        .rsp_valid_o(rsp_valid),
        .rsp_o      (cache_rsp)
    );

    task automatic fail_run(input string why);
        $display("Result: FAILED");
        $fatal(1, why);
    endtask

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", what, exp, act);
            fail_run("a checked value did not match");
        end
    endtask

    // Cycle limit, accepted requests and responses nobody asked for
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MaxCycles) fail_run("timeout, the run exceeded its cycle limit");
        if (rst_n) begin
            if (req_valid && req_ready) begin
                last_req = cache_req;
                if (cache_req.tid == TidAmo) amo_accepts = amo_accepts + 1;
            end
            check_value({cur_name, " st_rvalid"}, 64'd0, 64'(st_rsp.rvalid));
            if (!ld_waiting) check_value({cur_name, " ld_rvalid"}, 64'd0, 64'(ld_rsp.rvalid));
        end
    end

    task automatic finish_load(input row_t r);
        @(posedge clk);
        while (!ld_rsp.gnt) @(posedge clk);
        @(negedge clk);
        ld_req.req = 1'b0;
        @(posedge clk);
        while (!ld_rsp.rvalid) @(posedge clk);
        check_value({cur_name, " rdata"}, r.exp, ld_rsp.rdata);
        check_value({cur_name, " rid"}, 64'(r.id), 64'(ld_rsp.rid));
        @(negedge clk);
        ld_waiting = 1'b0;
    endtask

    task automatic run_row(input row_t r);
        int unsigned amo_before;
        logic        flush_taken;
        cur_name    = $sformatf("%0s", r.name);
        amo_before  = amo_accepts;
        flush_taken = 1'b0;
        @(negedge clk);
        if (r.kind == K_LOAD || r.kind == K_PAIR) begin
            ld_req     = '{req: 1'b1, addr: r.addr, wdata: '0, be: r.be, size: r.size,
                           id: r.id};
            ld_waiting = 1'b1;
        end
        if (r.kind == K_STORE || r.kind == K_PAIR) begin
            st_req = '{req: 1'b1, addr: r.addr, wdata: r.data, be: r.be, size: r.size,
                       id: 4'd0};
        end
        case (r.kind)
            K_LOAD: finish_load(r);
            K_STORE: begin
                @(posedge clk);
                while (!st_rsp.gnt) @(posedge clk);
                @(negedge clk);
                st_req.req = 1'b0;
            end
            K_AMO: begin
                amo_req = '{req: 1'b1, op: r.aop, size: r.size, operand_a: 64'(r.addr),
                            operand_b: r.data};
                @(posedge clk);
                while (!amo_rsp.ack) @(posedge clk);
                check_value({cur_name, " result"}, r.exp, amo_rsp.result);
                @(negedge clk);
                amo_req.req = 1'b0;
                check_value({cur_name, " amo issues"}, 64'd1, 64'(amo_accepts - amo_before));
            end
            K_FLUSH: begin
                flush = 1'b1;
                @(posedge clk);
                while (!flush_ack) begin
                    if (req_valid && req_ready && cache_req.op == DCACHE_FLUSH_ALL)
                        flush_taken = 1'b1;
                    @(posedge clk);
                end
                check_value({cur_name, " taken"}, 64'd1, 64'(flush_taken));
                @(negedge clk);
                flush = 1'b0;
            end
            default: begin
                // Store wins, load gnt stays low until the store goes
                @(posedge clk);
                while (!st_rsp.gnt) begin
                    check_value({cur_name, " ld_gnt"}, 64'd0, 64'(ld_rsp.gnt));
                    @(posedge clk);
                end
                check_value({cur_name, " ld_gnt"}, 64'd0, 64'(ld_rsp.gnt));
                @(negedge clk);
                st_req.req = 1'b0;
                finish_load(r);
            end
        endcase
        check_value({cur_name, " op"}, 64'(r.op), 64'(last_req.op));
        check_value({cur_name, " addr"}, 64'(r.addr),
                    64'({last_req.addr_tag, last_req.addr_offset}));
        check_value({cur_name, " sid"}, (r.kind == K_LOAD || r.kind == K_PAIR) ?
                    64'(LoadSid) : 64'(StoreSid), 64'(last_req.sid));
        check_value({cur_name, " tid"}, (r.kind == K_AMO) ? 64'(TidAmo) :
                    ((r.kind == K_LOAD || r.kind == K_PAIR) ? 64'(r.id) : 64'(TidFlush)),
                    64'(last_req.tid));
        check_value({cur_name, " need_rsp"}, 64'(r.kind != K_STORE),
                    64'(last_req.need_rsp));
        check_value({cur_name, " size"}, 64'(r.size), 64'(last_req.size));
        check_value({cur_name, " be"}, 64'(r.be), 64'(last_req.be));
        check_value({cur_name, " wdata"}, r.wd, last_req.wdata);
        check_value({cur_name, " uncacheable"}, 64'(r.unc), 64'(last_req.uncacheable));
    endtask

    initial begin
        void'($urandom(32'hb6a7));
        rst_n   = 1'b0;
        ld_req  = '0;
        st_req  = '0;
        amo_req = '0;
        flush   = 1'b0;
        // Model memory starts as word i = i * 0x0101010101010101
        rows[0]  = '{K_LOAD, AMO_NONE, 32'h8000_0008, 64'h0, 8'hff, 2'd3, 4'd3,
                     64'h0101_0101_0101_0101, 64'h0, DCACHE_LOAD, 1'b0, "load_basic"};
        rows[1]  = '{K_LOAD, AMO_NONE, 32'h0000_0018, 64'h0, 8'hff, 2'd3, 4'd4,
                     64'h0303_0303_0303_0303, 64'h0, DCACHE_LOAD, 1'b1, "load_uncached"};
        rows[2]  = '{K_STORE, AMO_NONE, 32'h8000_0010, 64'haaaa_bbbb_cccc_dddd, 8'h0f, 2'd3,
                     4'd0, 64'h0, 64'haaaa_bbbb_cccc_dddd, DCACHE_STORE, 1'b0, "store_part"};
        rows[3]  = '{K_LOAD, AMO_NONE, 32'h8000_0010, 64'h0, 8'hff, 2'd3, 4'd5,
                     64'h0202_0202_cccc_dddd, 64'h0, DCACHE_LOAD, 1'b0, "load_merged"};
        rows[4]  = '{K_STORE, AMO_NONE, 32'h8000_0020, 64'hf000_0001_0000_0000, 8'hf0, 2'd3,
                     4'd0, 64'h0, 64'hf000_0001_0000_0000, DCACHE_STORE, 1'b0, "store_upper"};
        rows[5]  = '{K_AMO, AMO_ADD, 32'h8000_0024, 64'h0000_0000_0000_0010, 8'hf0, 2'd2,
                     4'd0, 64'hffff_ffff_f000_0001, 64'h0000_0010_0000_0010, DCACHE_AMO_ADD,
                     1'b0, "amo_add_w"};
        rows[6]  = '{K_LOAD, AMO_NONE, 32'h8000_0020, 64'h0, 8'hff, 2'd3, 4'd6,
                     64'hf000_0011_0404_0404, 64'h0, DCACHE_LOAD, 1'b0, "load_sum"};
        rows[7]  = '{K_AMO, AMO_SWAP, 32'h0000_0030, 64'h1234_5678_9abc_def0, 8'hff, 2'd3,
                     4'd0, 64'h0606_0606_0606_0606, 64'h1234_5678_9abc_def0,
                     DCACHE_AMO_SWAP, 1'b1, "amo_swap_d"};
        rows[8]  = '{K_LOAD, AMO_NONE, 32'h0000_0030, 64'h0, 8'hff, 2'd3, 4'd7,
                     64'h1234_5678_9abc_def0, 64'h0, DCACHE_LOAD, 1'b1, "load_swap"};
        rows[9]  = '{K_FLUSH, AMO_NONE, 32'h0, 64'h0, 8'h00, 2'd0, 4'd0,
                     64'h0, 64'h0, DCACHE_FLUSH_ALL, 1'b0, "flush_all"};
        rows[10] = '{K_PAIR, AMO_NONE, 32'h8000_0038, 64'h5555_6666_7777_8888, 8'hff, 2'd3,
                     4'd2, 64'h5555_6666_7777_8888, 64'h0, DCACHE_LOAD, 1'b0, "pair_st_ld"};
        repeat (10) @(posedge clk);
        check_value("reset outputs", 64'd0, 64'({req_valid, ld_rsp.gnt, st_rsp.gnt,
                    ld_rsp.rvalid, amo_rsp.ack, flush_ack}));
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NumRows; i++) begin
            run_row(rows[i]);
        end
        @(negedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
source/core_if_pkg.sv
source/dcache_if_pkg.sv
source/load_port_adapter.sv
source/store_amo_adapter.sv
source/dcache_req_arbiter.sv
source/dcache_if_subsystem.sv
dv/tb_cache_model.sv
dv/tb_dcache_if_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_dcache_if_subsystem
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
